/* common/lz_pkg.sv */
package lz_pkg;

    // Bytes per input chunk, which is also the number of hash positions per beat.
    localparam int ISSUE_WIDTH = 16;

    // Bytes that one hash covers.
    localparam int COVER_BYTES = 4;

    // A window holds one chunk plus the bytes needed by its last positions.
    localparam int WINDOW_BYTES = ISSUE_WIDTH + COVER_BYTES - 1;

    localparam int ADDR_WIDTH = 16;  // Stream addresses wrap at this width.
    localparam int HASH_BITS = 6;
    localparam int HASH_ENTRIES = 1 << HASH_BITS;  // One history entry per hash value.

    // Golden-ratio multiplier; the hash is taken from the top bits of the low word.
    localparam logic [31:0] HASH_MULT = 32'h9E37_79B1;

    typedef logic [ISSUE_WIDTH*8-1:0]  chunk_t;    // Byte 0 sits in the low bits.
    typedef logic [WINDOW_BYTES*8-1:0] window_t;
    typedef logic [ADDR_WIDTH-1:0]     addr_t;
    typedef logic [HASH_BITS-1:0]      hash_t;
    typedef logic [ISSUE_WIDTH-1:0]    pos_mask_t; // One bit per position.

    // Input chunk as it arrives from the byte source.
    typedef struct packed {
        logic   delim;
        chunk_t data;
    } chunk_beat_t;

    // Window from the leftover buffer to the hash engine.
    typedef struct packed {
        logic    delim;
        addr_t   head_addr;
        window_t data;
    } window_beat_t;

    // Hashes of all positions in one window.
    typedef struct packed {
        logic                     delim;
        addr_t                    head_addr;
        pos_mask_t                pos_valid;
        hash_t [ISSUE_WIDTH-1:0]  hashes;
    } hash_beat_t;

    // Match candidates reported by the history table.
    typedef struct packed {
        logic                     delim;
        addr_t                    head_addr;
        pos_mask_t                pos_valid;
        pos_mask_t                hit;
        addr_t [ISSUE_WIDTH-1:0]  cand_addr;
    } match_beat_t;

    typedef enum logic [1:0] {
        WAIT,
        OUTPUT,
        FLUSH_DELIM
    } buf_state_t;

endpackage

/* hash/hash_engine.sv */
`timescale 1ns/1ps

module hash_engine
    import lz_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         win_valid,
    output logic         win_ready,
    input  window_beat_t win_beat,

    output logic         hash_valid,
    input  logic         hash_ready,
    output hash_beat_t   hash_beat
);

    // Multiplicative hash of one 4-byte word; the top bits of the low
    // 32-bit product mix all input bytes best.
    function automatic hash_t hash_of(input logic [COVER_BYTES*8-1:0] word);
        logic [31:0] prod;
        prod = word * HASH_MULT;
        return prod[31 -: HASH_BITS];
    endfunction

    hash_beat_t next_beat;
    logic       win_fire;

    // Accept a new window when the register is empty or drains this cycle.
    assign win_ready = !hash_valid || hash_ready;
    assign win_fire  = win_valid && win_ready;

    always_comb begin
        next_beat.delim     = win_beat.delim;
        next_beat.head_addr = win_beat.head_addr;
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            next_beat.hashes[p] = hash_of(win_beat.data[p*8 +: COVER_BYTES*8]);

            // On a flush window the last words would read the zero padding
            // past the end of the stream, so those positions are dropped.
            next_beat.pos_valid[p] = !win_beat.delim || (p + COVER_BYTES <= ISSUE_WIDTH);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hash_valid <= 1'b0;
        end else if (win_fire) begin
            hash_valid <= 1'b1;
        end else if (hash_ready) begin
            hash_valid <= 1'b0; // Beat was taken and nothing new came in.
        end
    end

    always_ff @(posedge clk) begin
        if (win_fire) begin
            hash_beat <= next_beat;
        end
    end

endmodule

/* hash/hash_history.sv */
`timescale 1ns/1ps

module hash_history
    import lz_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        hash_valid,
    output logic        hash_ready,
    input  hash_beat_t  hash_beat,

    output logic        out_valid,
    input  logic        out_ready,
    output match_beat_t out_beat
);

    // Last address seen for each hash value.
    addr_t tbl_addr [HASH_ENTRIES];
    logic [HASH_ENTRIES-1:0] tbl_valid;

    match_beat_t next_beat;
    logic        hash_fire;

    assign hash_ready = !out_valid || out_ready;
    assign hash_fire  = hash_valid && hash_ready;

    // Lookup for all 16 positions in one cycle. A position must see the
    // table as if every lower position had already been written, so a
    // matching lower position of the same beat overrides the table entry.
    always_comb begin
        next_beat.delim     = hash_beat.delim;
        next_beat.head_addr = hash_beat.head_addr;
        next_beat.pos_valid = hash_beat.pos_valid;
        next_beat.hit       = '0;
        next_beat.cand_addr = '0;
        for (int p = 0; p < ISSUE_WIDTH; p++) begin
            if (hash_beat.pos_valid[p]) begin
                if (tbl_valid[hash_beat.hashes[p]]) begin
                    next_beat.hit[p]       = 1'b1;
                    next_beat.cand_addr[p] = tbl_addr[hash_beat.hashes[p]];
                end

                // Ascending order leaves the closest lower position in place.
                for (int q = 0; q < ISSUE_WIDTH; q++) begin
                    if ((q < p) && hash_beat.pos_valid[q] &&
                        (hash_beat.hashes[q] == hash_beat.hashes[p])) begin
                        next_beat.hit[p]       = 1'b1;
                        next_beat.cand_addr[p] = hash_beat.head_addr + addr_t'(q);
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            tbl_valid <= '0;
        end else begin
            if (hash_fire) begin
                out_valid <= 1'b1;
                if (hash_beat.delim) begin
                    // End of stream, so the next stream starts with an empty history.
                    tbl_valid <= '0;
                end else begin
                    for (int p = 0; p < ISSUE_WIDTH; p++) begin
                        if (hash_beat.pos_valid[p]) begin
                            tbl_valid[hash_beat.hashes[p]] <= 1'b1;
                        end
                    end
                end
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hash_fire) begin
            out_beat <= next_beat;
            // Later positions are written last, so they win on equal hashes.
            for (int p = 0; p < ISSUE_WIDTH; p++) begin
                if (hash_beat.pos_valid[p]) begin
                    tbl_addr[hash_beat.hashes[p]] <= hash_beat.head_addr + addr_t'(p);
                end
            end
        end
    end

endmodule

/* leftover_buffer/input_leftover_buffer.sv */
`timescale 1ns/1ps

module input_leftover_buffer
    import lz_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  logic         in_valid,
    output logic         in_ready,
    input  chunk_beat_t  in_beat,

    output logic         win_valid,
    input  logic         win_ready,
    output window_beat_t win_beat
);

    // The buffer keeps one chunk back. Every window is the held chunk followed
    // by the first bytes of the next chunk, so positions near the end of a
    // chunk can still see all the bytes their hash covers.
    //   head_addr = 0,  data = bytes 0..18
    //   head_addr = 16, data = bytes 16..34
    // After the last chunk of a stream one extra flush window is sent with
    // zero padding in place of the missing bytes.

    buf_state_t state;
    chunk_t     held_chunk;
    addr_t      head_addr;

    logic [(COVER_BYTES-1)*8-1:0] lead_bytes;

    logic in_fire;
    logic win_fire;

    assign in_ready  = (state == WAIT) || ((state == OUTPUT) && win_ready);
    assign win_valid = ((state == OUTPUT) && in_valid) || (state == FLUSH_DELIM);

    assign in_fire  = in_valid && in_ready;
    assign win_fire = win_valid && win_ready;

    always_comb begin
        // The flush window has no following chunk, so its tail is zero.
        if (state == FLUSH_DELIM) begin
            lead_bytes = '0;
        end else begin
            lead_bytes = in_beat.data[(COVER_BYTES-1)*8-1:0];
        end
        win_beat.delim     = (state == FLUSH_DELIM); // Only flush beats end a stream.
        win_beat.head_addr = head_addr;
        win_beat.data      = {lead_bytes, held_chunk};
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= WAIT;
            head_addr <= '0;
        end else begin
            case (state)
                WAIT: begin
                    // First chunk of a stream is only stored.
                    if (in_fire) begin
                        state <= in_beat.delim ? FLUSH_DELIM : OUTPUT;
                    end
                end
                OUTPUT: begin
                    if (win_fire) begin
                        head_addr <= head_addr + addr_t'(ISSUE_WIDTH);
                        state     <= in_beat.delim ? FLUSH_DELIM : OUTPUT;
                    end
                end
                FLUSH_DELIM: begin
                    if (win_fire) begin
                        head_addr <= head_addr + addr_t'(ISSUE_WIDTH); // Addresses run on across streams.
                        state     <= WAIT;
                    end
                end
                default: begin
                    state <= WAIT;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            held_chunk <= in_beat.data; // Becomes the body of the next window.
        end
    end

endmodule

/* sim.f */
+incdir+verif
common/lz_pkg.sv
leftover_buffer/input_leftover_buffer.sv
hash/hash_engine.sv
hash/hash_history.sv
verilog/lz_hash_front.sv
verif/tb_lz_hash_front.sv

/* verif/lz_ref_model.svh */
`ifndef LZ_REF_MODEL_SVH
`define LZ_REF_MODEL_SVH

// Reference model of the hash front end. It works on whole chunks as they
// are accepted and queues the match beats that the DUT must produce.

logic        model_have_held;              // A chunk of the current stream is waiting.
chunk_t      model_held;
addr_t       model_head;                   // Address of the next window's first byte.
addr_t       model_tbl_addr [HASH_ENTRIES];
logic        model_tbl_valid [HASH_ENTRIES];
match_beat_t expected_q [$];

// Multiplicative hash, the top bits of the low product word.
function automatic hash_t hash_word(input logic [31:0] word);
    logic [63:0] full;
    full = 64'(word) * 64'(HASH_MULT);
    return hash_t'(full[31:0] >> (32 - HASH_BITS));
endfunction

// The 4-byte word that starts at position p, with byte p as its low byte.
function automatic logic [31:0] word_at(input window_t data, input int p);
    logic [31:0] word;
    word = '0;
    for (int b = 0; b < COVER_BYTES; b++) begin
        word[b*8 +: 8] = data[(p + b)*8 +: 8];
    end
    return word;
endfunction

task automatic clear_model();
    model_have_held = 1'b0;
    model_held      = '0;
    model_head      = '0;
    for (int h = 0; h < HASH_ENTRIES; h++) begin
        model_tbl_addr[h]  = '0;
        model_tbl_valid[h] = 1'b0;
    end
    expected_q.delete();
endtask

// Hashes one window, walks the history in position order and queues the result.
task automatic push_window(input window_t data, input logic delim);
    match_beat_t beat;
    hash_t       h;
    int          p;
    beat           = '0;
    beat.delim     = delim;
    beat.head_addr = model_head;
    for (p = 0; p < ISSUE_WIDTH; p++) begin
        // A flush window only has whole words for positions whose last byte is real.
        beat.pos_valid[p] = !delim || (p + COVER_BYTES - 1 < ISSUE_WIDTH);
        if (beat.pos_valid[p]) begin
            h = hash_word(word_at(data, p));
            if (model_tbl_valid[h]) begin
                beat.hit[p]       = 1'b1;
                beat.cand_addr[p] = model_tbl_addr[h];
            end
            model_tbl_addr[h]  = model_head + addr_t'(p);
            model_tbl_valid[h] = 1'b1;
        end
    end
    if (delim) begin
        for (int e = 0; e < HASH_ENTRIES; e++) begin
            model_tbl_valid[e] = 1'b0; // A new stream starts with no history.
        end
    end
    model_head = model_head + addr_t'(ISSUE_WIDTH);
    expected_q.push_back(beat);
endtask

// Windowing of one accepted chunk.
task automatic accept_chunk(input chunk_beat_t c);
    if (model_have_held) begin
        push_window({c.data[(COVER_BYTES-1)*8-1:0], model_held}, 1'b0);
    end
    model_held      = c.data;
    model_have_held = 1'b1;
    if (c.delim) begin
        push_window({{(COVER_BYTES-1)*8{1'b0}}, model_held}, 1'b1);
        model_have_held = 1'b0;
    end
endtask

`endif

/* verif/tb_lz_hash_front.sv */
`timescale 1ns/1ps

module tb_lz_hash_front
    import lz_pkg::*;
();

    localparam int NUM_CHUNKS     = 400;
    localparam int TIMEOUT_CYCLES = NUM_CHUNKS * 8 + 200;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic        in_ready;
    chunk_beat_t in_beat;
    logic        out_valid;
    logic        out_ready;
    match_beat_t out_beat;

    integer seed;
    int     sent;
    int     cycle_count;
    int     beats_seen;
    logic   in_taken;      // Input transfers at the coming rising edge.
    logic   after_flush;   // Next output beat opens a stream.

    `include "lz_ref_model.svh"

    lz_hash_front i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_beat  (out_beat)
    );

    always #5 clk = ~clk;

    task automatic stop_run();
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_addr(input string name, input addr_t exp, input addr_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_mask(input string name, input pos_mask_t exp, input pos_mask_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s: expected %b, actual %b", name, exp, act);
            stop_run();
        end
    endtask

    function automatic chunk_beat_t random_chunk(input logic last);
        chunk_beat_t c;
        for (int w = 0; w < ISSUE_WIDTH / 4; w++) begin
            c.data[w*32 +: 32] = $random(seed);
        end
        c.delim = last || (({$random(seed)} % 8) == 0); // Roughly one stream end in eight.
        return c;
    endfunction

    task automatic compare_beat(input match_beat_t act);
        match_beat_t exp;
        string       tag;
        int          p;
        if (expected_q.size() == 0) begin
            $display("The DUT sent an output beat that the model did not expect.");
            stop_run();
        end else begin
            exp = expected_q.pop_front();
            tag = $sformatf("beat %0d", beats_seen);
            check_bit({tag, " delim"}, exp.delim, act.delim);
            check_addr({tag, " head_addr"}, exp.head_addr, act.head_addr);
            check_mask({tag, " pos_valid"}, exp.pos_valid, act.pos_valid);
            check_mask({tag, " hit"}, exp.hit, act.hit);
            for (p = 0; p < ISSUE_WIDTH; p++) begin
                if (exp.hit[p]) begin
                    check_addr($sformatf("%s cand_addr[%0d]", tag, p),
                               exp.cand_addr[p], act.cand_addr[p]);
                end
                // The first beat of a stream can only point at its own lower positions.
                if (after_flush && act.hit[p]) begin
                    check_bit($sformatf("%s isolation[%0d]", tag, p), 1'b1,
                              addr_t'(act.cand_addr[p] - act.head_addr) < addr_t'(p));
                end
            end
            after_flush = act.delim;
            beats_seen++;
        end
    endtask

    // Handshakes are stable at the falling edge, half a cycle before they transfer.
    always @(negedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d cycles with %0d beats still expected.",
                     cycle_count, expected_q.size());
            stop_run();
        end else begin
            in_taken = rst_n && in_valid && in_ready;
            if (rst_n && out_valid && out_ready) begin
                compare_beat(out_beat);
            end
            if (in_taken) begin
                accept_chunk(in_beat);
            end
        end
    end

    initial begin
        seed        = 32'h45bb_c461;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_beat     = '0;
        out_ready   = 1'b0;
        sent        = 0;
        cycle_count = 0;
        beats_seen  = 0;
        in_taken    = 1'b0;
        after_flush = 1'b1;
        clear_model();

        repeat (2) begin
            @(posedge clk);
            #1;
            check_bit("reset out_valid", 1'b0, out_valid);
            check_bit("reset in_ready", 1'b1, in_ready);
        end
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        check_bit("post-reset out_valid", 1'b0, out_valid);
        check_bit("post-reset in_ready", 1'b1, in_ready);

        while (sent < NUM_CHUNKS) begin
            if (in_valid && in_taken) begin
                sent++;
                in_valid = 1'b0;
            end
            if (!in_valid && (sent < NUM_CHUNKS)) begin
                if (({$random(seed)} % 4) != 0) begin
                    in_beat  = random_chunk(sent == NUM_CHUNKS - 1);
                    in_valid = 1'b1;
                end
            end
            out_ready = ({$random(seed)} % 10) < 7;
            @(posedge clk);
            #1;
        end

        // Drain the pipeline under the same back-pressure.
        while (expected_q.size() != 0) begin
            out_ready = ({$random(seed)} % 10) < 7;
            @(posedge clk);
            #1;
        end
        out_ready = 1'b1;
        repeat (10) @(posedge clk); // Any extra beat shows up here.

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* verilog/lz_hash_front.sv */
`timescale 1ns/1ps

module lz_hash_front
    import lz_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        in_valid,
    output logic        in_ready,
    input  chunk_beat_t in_beat,

    output logic        out_valid,
    input  logic        out_ready,
    output match_beat_t out_beat
);

    // Buffer to engine.
    logic         win_valid;
    logic         win_ready;
    window_beat_t win_beat;

    // Engine to history table.
    logic         hash_valid;
    logic         hash_ready;
    hash_beat_t   hash_beat;

    // Regroups chunks into overlapping windows and tracks stream addresses.
    input_leftover_buffer i_buffer (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_beat   (in_beat),
        .win_valid (win_valid),
        .win_ready (win_ready),
        .win_beat  (win_beat)
    );

    hash_engine i_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_valid  (win_valid),
        .win_ready  (win_ready),
        .win_beat   (win_beat),
        .hash_valid (hash_valid),
        .hash_ready (hash_ready),
        .hash_beat  (hash_beat)
    );

    // Final stage. Its output register drives the top-level outputs.
    hash_history i_history (
        .clk        (clk),
        .rst_n      (rst_n),
        .hash_valid (hash_valid),
        .hash_ready (hash_ready),
        .hash_beat  (hash_beat),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_beat   (out_beat)
    );

endmodule
